//--- common/snakePkg.sv
`default_nettype none

package snakePkg;

	localparam int GRID_BITS = 4;
	localparam int CELL_BITS = 2 * GRID_BITS;

	// playable area, row and column 0 and 15 are wall.
	localparam int BOARD_MIN = 1;
	localparam int BOARD_MAX = 14;

	localparam int MAX_LENGTH = 8;
	localparam int START_LENGTH = 3;
	localparam int START_X = 7;
	localparam int START_Y = 7;

	localparam int STEP_CYCLES = 4;
	localparam logic [CELL_BITS-1:0] LFSR_SEED = 8'hA5;

	typedef enum logic [1:0] {
		stIdle = 2'd0,
		stRun  = 2'd1,
		stOver = 2'd2
	} gameState;

	// bit positions in the one-hot direction word.
	localparam int dirUp = 0;
	localparam int dirDown = 1;
	localparam int dirLeft = 2;
	localparam int dirRight = 3;

	typedef struct packed {
		logic [GRID_BITS-1:0] x;
		logic [GRID_BITS-1:0] y;
	} cellPos;

	typedef union packed {
		cellPos pos;
		logic [CELL_BITS-1:0] idx;
	} cellT;

endpackage

`default_nettype wire

//--- hw/gameFsm.sv
`timescale 1ns/1ps
`default_nettype none

module gameFsm import snakePkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  logic     start,
	input  logic     hit,
	input  logic     complete,
	input  logic     step,
	output logic     run,
	output logic     restart,
	output logic     gameOver,
	output gameState state
);

	gameState nextState;

	always_comb begin
		nextState = state;
		case (state)
			stIdle: begin
				if (start) begin
					nextState = stRun;
				end
			end
			stRun: begin
				// complete is stale while restart is high.
				if ((step && hit) || (complete && !restart)) begin
					nextState = stOver;
				end
			end
			stOver: begin
				if (start) begin
					nextState = stRun;
				end
			end
			default: begin
				nextState = stIdle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			restart <= 1'b0;
		end else begin
			state <= nextState;
			restart <= (nextState == stRun) && (state != stRun); // one cycle per start.
		end
	end

	assign run = (state == stRun);
	assign gameOver = (state == stOver);

endmodule

`default_nettype wire

//--- hw/stepTimer.sv
`timescale 1ns/1ps
`default_nettype none

module stepTimer import snakePkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic run,
	output logic step
);

	logic [$clog2(STEP_CYCLES)-1:0] count;
	logic wrap;

	assign wrap = (count == ($bits(count))'(STEP_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (!rstN || !run) begin
			count <= '0;
		end else if (wrap) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// registered, so the first pulse lands STEP_CYCLES after run rises.
	always_ff @(posedge clk) begin
		if (!rstN || !run) begin
			step <= 1'b0;
		end else begin
			step <= wrap;
		end
	end

endmodule

`default_nettype wire

//--- snake/snakeBody.sv
`timescale 1ns/1ps
`default_nettype none

module snakeBody import snakePkg::*; (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             restart,
	input  logic                             step,
	input  logic                             hit,
	input  logic                             eat,
	input  logic [3:0]                       dirIn,
	output cellT                             head,
	output cellT                             nextHead,
	output logic [MAX_LENGTH*CELL_BITS-1:0]  body,
	output logic [3:0]                       length
);

	cellT cells [MAX_LENGTH];
	logic [3:0] dirReg;
	logic [3:0] dirNow;
	logic dirOneHot;
	logic reverse;

	always_comb begin
		dirOneHot = (dirIn != 4'b0) && ((dirIn & (dirIn - 4'd1)) == 4'b0);
		reverse = (dirIn[dirUp] && dirReg[dirDown]) ||
			(dirIn[dirDown] && dirReg[dirUp]) ||
			(dirIn[dirLeft] && dirReg[dirRight]) ||
			(dirIn[dirRight] && dirReg[dirLeft]);
		dirNow = (dirOneHot && !reverse) ? dirIn : dirReg; // keep old heading.
	end

	always_comb begin
		nextHead = cells[0];
		if (dirNow[dirUp]) begin
			nextHead.pos.y = cells[0].pos.y - 1'b1;
		end else if (dirNow[dirDown]) begin
			nextHead.pos.y = cells[0].pos.y + 1'b1;
		end else if (dirNow[dirLeft]) begin
			nextHead.pos.x = cells[0].pos.x - 1'b1;
		end else if (dirNow[dirRight]) begin
			nextHead.pos.x = cells[0].pos.x + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN || restart) begin
			dirReg <= 4'(1 << dirRight);
			length <= 4'(START_LENGTH);
			for (int i = 0; i < MAX_LENGTH; i++) begin
				cells[i].pos.x <= GRID_BITS'(START_X - i); // trails to the left.
				cells[i].pos.y <= GRID_BITS'(START_Y);
			end
		end else if (step && !hit) begin
			dirReg <= dirNow;
			cells[0] <= nextHead;
			for (int i = 1; i < MAX_LENGTH; i++) begin
				cells[i] <= cells[i-1];
			end
			if (eat && (length < 4'(MAX_LENGTH))) begin
				length <= length + 4'd1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < MAX_LENGTH; i++) begin
			body[i*CELL_BITS +: CELL_BITS] = cells[i].idx;
		end
	end

	assign head = cells[0];

endmodule

`default_nettype wire

//--- snake/collisionCheck.sv
`timescale 1ns/1ps
`default_nettype none

module collisionCheck import snakePkg::*; (
	input  cellT                            nextHead,
	input  logic [MAX_LENGTH*CELL_BITS-1:0] body,
	input  logic [3:0]                      length,
	input  cellT                            apple,
	output logic                            eat,
	output logic                            hit
);

	logic wall;
	logic selfHit;

	always_comb begin
		wall = (nextHead.pos.x < BOARD_MIN) || (nextHead.pos.x > BOARD_MAX) ||
			(nextHead.pos.y < BOARD_MIN) || (nextHead.pos.y > BOARD_MAX);
	end

	// the tail cell leaves on this step, so it is skipped.
	always_comb begin
		selfHit = 1'b0;
		for (int i = 0; i < MAX_LENGTH; i++) begin
			if ((i + 1 < int'(length)) &&
				(body[i*CELL_BITS +: CELL_BITS] == nextHead.idx)) begin
				selfHit = 1'b1;
			end
		end
	end

	assign hit = wall || selfHit;
	assign eat = !hit && (nextHead.idx == apple.idx);

endmodule

`default_nettype wire

//--- hw/appleGen.sv
`timescale 1ns/1ps
`default_nettype none

module appleGen import snakePkg::*; (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            restart,
	input  logic                            step,
	input  logic                            eat,
	input  logic [MAX_LENGTH*CELL_BITS-1:0] body,
	input  logic [3:0]                      length,
	output cellT                            apple,
	output logic                            appleValid
);

	logic [CELL_BITS-1:0] lfsr;
	logic seeking;
	logic inBoard;
	logic covered;
	logic found;
	cellT cand;

	always_comb begin
		cand.idx = lfsr;
		inBoard = (cand.pos.x >= BOARD_MIN) && (cand.pos.x <= BOARD_MAX) &&
			(cand.pos.y >= BOARD_MIN) && (cand.pos.y <= BOARD_MAX);
		covered = 1'b0;
		for (int i = 0; i < MAX_LENGTH; i++) begin
			if ((i < int'(length)) && (body[i*CELL_BITS +: CELL_BITS] == cand.idx)) begin
				covered = 1'b1;
			end
		end
	end

	assign found = seeking && inBoard && !covered;

	// taps 8, 6, 5, 4.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			lfsr <= LFSR_SEED;
		end else begin
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			seeking <= 1'b0;
			appleValid <= 1'b0;
		end else if (restart || (step && eat)) begin
			seeking <= 1'b1;
			appleValid <= 1'b0;
		end else if (found) begin
			seeking <= 1'b0;
			appleValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (found) begin
			apple <= cand;
		end
	end

endmodule

`default_nettype wire

//--- hw/scoreTracker.sv
`timescale 1ns/1ps
`default_nettype none

module scoreTracker import snakePkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  logic       restart,
	input  logic       step,
	input  logic       eat,
	output logic [3:0] ones,
	output logic [3:0] tens,
	output logic       complete
);

	logic [3:0] count;

	always_ff @(posedge clk) begin
		if (!rstN || restart) begin
			count <= 4'(START_LENGTH);
			ones <= 4'(START_LENGTH);
			tens <= 4'd0;
		end else if (step && eat && !complete) begin
			count <= count + 4'd1;
			if (ones == 4'd9) begin
				ones <= 4'd0; // decimal carry.
				tens <= tens + 4'd1;
			end else begin
				ones <= ones + 4'd1;
			end
		end
	end

	assign complete = (count == 4'(MAX_LENGTH));

endmodule

`default_nettype wire

//--- hw/snakeTop.sv
`timescale 1ns/1ps
`default_nettype none

module snakeTop import snakePkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  logic       start,
	input  logic [3:0] dirIn,
	output logic [3:0] headX,
	output logic [3:0] headY,
	output logic [3:0] appleX,
	output logic [3:0] appleY,
	output logic       appleValid,
	output logic       step,
	output logic       gameOver,
	output logic       running,
	output logic [3:0] ones,
	output logic [3:0] tens
);

	logic run;
	logic restart;
	logic hit;
	logic eat;
	logic complete;
	gameState state;
	cellT head;
	cellT nextHead;
	cellT apple;
	logic [MAX_LENGTH*CELL_BITS-1:0] body;
	logic [3:0] length;

	gameFsm fsm (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.hit(hit),
		.complete(complete),
		.step(step),
		.run(run),
		.restart(restart),
		.gameOver(gameOver),
		.state(state)
	);

	stepTimer timer (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.step(step)
	);

	snakeBody snake (
		.clk(clk),
		.rstN(rstN),
		.restart(restart),
		.step(step),
		.hit(hit),
		.eat(eat),
		.dirIn(dirIn),
		.head(head),
		.nextHead(nextHead),
		.body(body),
		.length(length)
	);

	collisionCheck coll (
		.nextHead(nextHead),
		.body(body),
		.length(length),
		.apple(apple),
		.eat(eat),
		.hit(hit)
	);

	appleGen apples (
		.clk(clk),
		.rstN(rstN),
		.restart(restart),
		.step(step),
		.eat(eat),
		.body(body),
		.length(length),
		.apple(apple),
		.appleValid(appleValid)
	);

	scoreTracker score (
		.clk(clk),
		.rstN(rstN),
		.restart(restart),
		.step(step),
		.eat(eat),
		.ones(ones),
		.tens(tens),
		.complete(complete)
	);

	assign headX = head.pos.x;
	assign headY = head.pos.y;
	assign appleX = apple.pos.x;
	assign appleY = apple.pos.y;
	assign running = (state == stRun);

endmodule

`default_nettype wire

//--- test/snakeTop_assert.sv
`timescale 1ns/1ps
`default_nettype none

module snakeTopChecks import snakePkg::*; (
	input logic       clk,
	input logic       rstN,
	input logic       step,
	input logic       running,
	input logic       gameOver,
	input logic       appleValid,
	input logic [3:0] headX,
	input logic [3:0] headY
);

	stepSingle: assert property (@(posedge clk) disable iff (!rstN)
		step |=> !step)
		else $error("step high on two consecutive cycles");

	overQuiet: assert property (@(posedge clk) disable iff (!rstN)
		gameOver |-> !step)
		else $error("step high while the game is over");

	headInBoard: assert property (@(posedge clk) disable iff (!rstN)
		running |-> (headX >= BOARD_MIN) && (headX <= BOARD_MAX) &&
			(headY >= BOARD_MIN) && (headY <= BOARD_MAX))
		else $error("head left the board while running");

	// relocation is bounded by one step period.
	appleBack: assert property (@(posedge clk) disable iff (!rstN)
		$fell(appleValid) |-> ##[1:STEP_CYCLES] appleValid)
		else $error("apple relocation took too long");

endmodule

bind snakeTop snakeTopChecks checks (
	.clk(clk),
	.rstN(rstN),
	.step(step),
	.running(running),
	.gameOver(gameOver),
	.appleValid(appleValid),
	.headX(headX),
	.headY(headY)
);

`default_nettype wire

//--- test/snakeTb.sv
`timescale 1ns/1ps
`default_nettype none

module snakeTb import snakePkg::*; ();

	localparam int NUM_ROWS = 36;
	localparam int CLK_PERIOD = 4;
	localparam int MARGIN_NS = 1000;

	logic clk;
	logic rstN;
	logic start;
	logic [3:0] dirIn;
	logic [3:0] headX;
	logic [3:0] headY;
	logic [3:0] appleX;
	logic [3:0] appleY;
	logic appleValid;
	logic step;
	logic gameOver;
	logic running;
	logic [3:0] ones;
	logic [3:0] tens;

	// dir, start, headX, headY, appleX, appleY, ones, tens, gameOver.
	logic [35:0] cases [NUM_ROWS];

	snakeTop UUT (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.dirIn(dirIn),
		.headX(headX),
		.headY(headY),
		.appleX(appleX),
		.appleY(appleY),
		.appleValid(appleValid),
		.step(step),
		.gameOver(gameOver),
		.running(running),
		.ones(ones),
		.tens(tens)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic checkVal(input string name, input logic [3:0] actual,
			input logic [3:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual,
				expected);
			$display("Errors found");
			$fatal(1, "stopping at the first failed check");
		end
	endtask

	// returns 1 ns after the edge that raised step.
	task automatic waitStep();
		while (!step) begin
			@(posedge clk);
			#1;
		end
	endtask

	// head and score settle on the next edge, the apple may need a few more.
	task automatic waitSettled();
		@(posedge clk);
		#1;
		@(posedge clk);
		#1;
		while (!appleValid) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		logic [35:0] row;
		clk = 1'b0;
		rstN = 1'b0;
		start = 1'b0;
		dirIn = 4'b0;
		$readmemh("test/snake_cases.mem", cases);
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			row = cases[r];
			dirIn = row[35:32];
			start = row[28];
			waitStep();
			waitSettled();
			checkVal("headX", headX, row[27:24]);
			checkVal("headY", headY, row[23:20]);
			checkVal("appleX", appleX, row[19:16]);
			checkVal("appleY", appleY, row[15:12]);
			checkVal("ones", ones, row[11:8]);
			checkVal("tens", tens, row[7:4]);
			checkVal("gameOver", {3'b0, gameOver}, row[3:0]);
			checkVal("running", {3'b0, running}, {3'b0, ~row[0]}); // started game runs until over.
		end
		$display("No errors");
		$finish;
	end

	// each row takes about one step period.
	initial begin
		#(NUM_ROWS * STEP_CYCLES * CLK_PERIOD + MARGIN_NS);
		$display("Timeout: the DUT stopped producing step pulses before all cases ran");
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- test/snake_cases.mem
// dir start headX headY appleX appleY ones tens gameOver, one nibble each
// dir is one-hot: 1 up, 2 down, 4 left, 8 right
8_1_8_7_9_5_3_0_0
1_0_8_6_9_5_3_0_0
2_0_8_5_9_5_3_0_0
8_0_9_5_B_3_4_0_0
8_0_A_5_B_3_4_0_0
8_0_B_5_B_3_4_0_0
1_0_B_4_B_3_4_0_0
1_0_B_3_A_6_5_0_0
4_0_A_3_A_6_5_0_0
2_0_A_4_A_6_5_0_0
2_0_A_5_A_6_5_0_0
2_0_A_6_C_1_6_0_0
8_0_B_6_C_1_6_0_0
8_0_C_6_C_1_6_0_0
1_0_C_5_C_1_6_0_0
1_0_C_4_C_1_6_0_0
1_0_C_3_C_1_6_0_0
1_0_C_2_C_1_6_0_0
1_0_C_1_8_4_7_0_0
4_0_B_1_8_4_7_0_0
4_0_A_1_8_4_7_0_0
4_0_9_1_8_4_7_0_0
4_0_8_1_8_4_7_0_0
4_0_7_1_8_4_7_0_0
2_0_7_2_8_4_7_0_0
2_0_7_3_8_4_7_0_0
2_0_7_4_8_4_7_0_0
8_0_8_4_1_1_8_0_1
8_1_8_7_8_E_3_0_0
1_0_8_6_8_E_3_0_0
1_0_8_5_8_E_3_0_0
1_0_8_4_8_E_3_0_0
1_0_8_3_8_E_3_0_0
1_0_8_2_8_E_3_0_0
1_0_8_1_8_E_3_0_0
1_0_8_1_8_E_3_0_1

//--- snakeGame.f
common/snakePkg.sv
hw/gameFsm.sv
hw/stepTimer.sv
snake/snakeBody.sv
snake/collisionCheck.sv
hw/appleGen.sv
hw/scoreTracker.sv
hw/snakeTop.sv
test/snakeTop_assert.sv
test/snakeTb.sv
